/* common/n3xx_macros.svh */
// widths and register map constants; the stream switch logic assumes exactly 2 ports
`ifndef N3XX_MACROS_SVH
`define N3XX_MACROS_SVH

// register port
`define N3XX_REG_AWIDTH 14
`define N3XX_REG_DWIDTH 32

// stream side
`define N3XX_STREAM_WIDTH  64
`define N3XX_NUM_PORTS     2
`define N3XX_ROUTE_ENTRIES 16   // one entry per 4-bit destination

// routing table window
`define N3XX_REG_BASE_XBAR 14'h1000

// design revision word
`define N3XX_COMPAT_MAJOR 16'd1
`define N3XX_COMPAT_MINOR 16'd0

`endif

/* common/n3xx_pkg.sv */
// register map and stream types; route entries are one bit wide so only 2 outputs fit
`include "n3xx_macros.svh"

package n3xx_pkg;

  ////////////////////
  // register port
  typedef logic [`N3XX_REG_AWIDTH-1:0] reg_addr_t;
  typedef logic [`N3XX_REG_DWIDTH-1:0] reg_data_t;

  // misc bank addresses
  typedef enum logic [`N3XX_REG_AWIDTH-1:0] {
    DESIGN_REV  = 14'h0,
    BUS_COUNTER = 14'hC,
    NUM_CE      = 14'h10,
    SCRATCH     = 14'h14,
    CLOCK_CTRL  = 14'h18
  } mb_reg_addr_e;

  ////////////////////
  // streams
  typedef logic [`N3XX_STREAM_WIDTH-1:0] stream_data_t;

  // bit i names the output for destination i
  typedef logic [`N3XX_ROUTE_ENTRIES-1:0] route_table_t;

  // per-output switch state
  typedef enum logic {
    IDLE,
    BUSY
  } out_state_e;

endpackage

/* common/regport_if.sv */
// requests carry no handshake; rd_resp is a one-cycle pulse one cycle after a hit
interface regport_if;

  logic                wr_req;
  n3xx_pkg::reg_addr_t wr_addr;
  n3xx_pkg::reg_data_t wr_data;
  logic                rd_req;
  n3xx_pkg::reg_addr_t rd_addr;
  logic                rd_resp;   // driven by the decoding slave only
  n3xx_pkg::reg_data_t rd_data;

  modport master (
    output wr_req, wr_addr, wr_data, rd_req, rd_addr,
    input  rd_resp, rd_data
  );

  modport slave (
    input  wr_req, wr_addr, wr_data, rd_req, rd_addr,
    output rd_resp, rd_data
  );

endinterface

/* common/axis_if.sv */
// 64-bit stream; source holds tdata and tlast while tvalid waits for tready
interface axis_if;

  n3xx_pkg::stream_data_t tdata;
  logic                   tlast;
  logic                   tvalid;
  logic                   tready;

  modport source (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport sink (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface

/* source/mb_regs.sv */
// lock inputs may be asynchronous and are seen 2 cycles late; reads assume one request in flight
`include "n3xx_macros.svh"

module mb_regs (
  input  logic       bus_clk,
  input  logic       bus_rst,
  input  logic       i_ref_clk_locked,
  input  logic       i_meas_clk_locked,
  regport_if.slave   reg_port,
  output logic [3:0] o_pps_select,
  output logic       o_pps_out_enb,
  output logic       o_ref_clk_reset,
  output logic       o_meas_clk_reset
);

  n3xx_pkg::reg_data_t scratch_reg;
  n3xx_pkg::reg_data_t bus_counter;
  n3xx_pkg::reg_data_t rd_mux;
  logic                rd_hit;
  logic [1:0]          ref_lock_sync;   // bit 1 is the settled value
  logic [1:0]          meas_lock_sync;

  ////////////////////
  // counter and lock synchronizers
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      bus_counter    <= '0;
      ref_lock_sync  <= '0;
      meas_lock_sync <= '0;
    end else begin
      bus_counter    <= bus_counter + 1'b1;
      ref_lock_sync  <= {ref_lock_sync[0], i_ref_clk_locked};
      meas_lock_sync <= {meas_lock_sync[0], i_meas_clk_locked};
    end
  end

  ////////////////////
  // writes
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      scratch_reg      <= '0;
      o_pps_select     <= 4'h1;   // internal pps by default
      o_pps_out_enb    <= 1'b0;
      o_ref_clk_reset  <= 1'b0;
      o_meas_clk_reset <= 1'b0;
    end else if (reg_port.wr_req) begin
      case (reg_port.wr_addr)
        n3xx_pkg::SCRATCH: scratch_reg <= reg_port.wr_data;
        n3xx_pkg::CLOCK_CTRL: begin
          o_pps_select     <= reg_port.wr_data[3:0];
          o_pps_out_enb    <= reg_port.wr_data[4];
          o_ref_clk_reset  <= reg_port.wr_data[8];
          o_meas_clk_reset <= reg_port.wr_data[12];
        end
        default: ;
      endcase
    end
  end

  // read decode, silent outside our five addresses
  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    case (reg_port.rd_addr)
      n3xx_pkg::DESIGN_REV:  rd_mux = {`N3XX_COMPAT_MAJOR, `N3XX_COMPAT_MINOR};
      n3xx_pkg::BUS_COUNTER: rd_mux = bus_counter;
      n3xx_pkg::NUM_CE:      rd_mux = `N3XX_REG_DWIDTH'(`N3XX_NUM_PORTS);
      n3xx_pkg::SCRATCH:     rd_mux = scratch_reg;
      n3xx_pkg::CLOCK_CTRL: begin
        rd_mux[3:0] = o_pps_select;
        rd_mux[4]   = o_pps_out_enb;
        rd_mux[8]   = o_ref_clk_reset;
        rd_mux[9]   = ref_lock_sync[1];
        rd_mux[12]  = o_meas_clk_reset;
        rd_mux[13]  = meas_lock_sync[1];
      end
      default: rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) reg_port.rd_resp <= 1'b0;
    else         reg_port.rd_resp <= reg_port.rd_req && rd_hit;
  end

  always_ff @(posedge bus_clk) begin
    if (reg_port.rd_req) reg_port.rd_data <= rd_mux;   // held until the next read
  end

  // master spaces its reads, so every response is a single pulse
  a_resp_pulse : assert property (@(posedge bus_clk) disable iff (bus_rst)
    reg_port.rd_resp |=> !reg_port.rd_resp);

endmodule

/* source/regport_resp_mux.sv */
// adds one cycle to every read; at most one slave may answer in a given cycle
`include "n3xx_macros.svh"

module regport_resp_mux #(
  parameter int NUM_SLAVES = 2
) (
  input  logic                                       bus_clk,
  input  logic                                       bus_rst,
  input  logic [NUM_SLAVES-1:0]                      i_slave_resp,
  input  logic [NUM_SLAVES-1:0][`N3XX_REG_DWIDTH-1:0] i_slave_data,
  output logic                                       o_rd_resp,
  output logic [`N3XX_REG_DWIDTH-1:0]                o_rd_data
);

  logic [`N3XX_REG_DWIDTH-1:0] data_or;

  always_comb begin
    data_or = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (i_slave_resp[s]) data_or = data_or | i_slave_data[s];   // idle slaves masked off
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) o_rd_resp <= 1'b0;
    else         o_rd_resp <= |i_slave_resp;
  end

  always_ff @(posedge bus_clk) begin
    if (|i_slave_resp) o_rd_data <= data_or;
  end

  // address windows of the slaves must not overlap
  a_one_slave : assert property (@(posedge bus_clk) disable iff (bus_rst)
    $onehot0(i_slave_resp));

endmodule

/* xbar/xbar_route_table.sv */
// window is base to base+0x3C, entry = offset/4; only data bit 0 is stored
`include "n3xx_macros.svh"

module xbar_route_table (
  input  logic                   bus_clk,
  input  logic                   bus_rst,
  regport_if.slave               reg_port,
  output n3xx_pkg::route_table_t o_route
);

  localparam int IDX_W = $clog2(`N3XX_ROUTE_ENTRIES);
  localparam n3xx_pkg::reg_addr_t SPAN =
    n3xx_pkg::reg_addr_t'(4 * (`N3XX_ROUTE_ENTRIES - 1));   // last entry offset

  n3xx_pkg::reg_addr_t wr_offset;
  n3xx_pkg::reg_addr_t rd_offset;
  logic [IDX_W-1:0]    wr_entry;
  logic [IDX_W-1:0]    rd_entry;

  // below the base wraps to a large offset and misses
  assign wr_offset = reg_port.wr_addr - `N3XX_REG_BASE_XBAR;
  assign rd_offset = reg_port.rd_addr - `N3XX_REG_BASE_XBAR;
  assign wr_entry  = wr_offset[IDX_W+1:2];
  assign rd_entry  = rd_offset[IDX_W+1:2];

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int i = 0; i < `N3XX_ROUTE_ENTRIES; i++) begin
        o_route[i] <= i[0];   // even dests to out0, odd to out1
      end
    end else if (reg_port.wr_req && (wr_offset <= SPAN)) begin
      o_route[wr_entry] <= reg_port.wr_data[0];
    end
  end

  ////////////////////
  // readback
  always_ff @(posedge bus_clk) begin
    if (bus_rst) reg_port.rd_resp <= 1'b0;
    else         reg_port.rd_resp <= reg_port.rd_req && (rd_offset <= SPAN);
  end

  always_ff @(posedge bus_clk) begin
    if (reg_port.rd_req) begin
      reg_port.rd_data <= {{(`N3XX_REG_DWIDTH-1){1'b0}}, o_route[rd_entry]};
    end
  end

endmodule

/* xbar/xbar_stream_switch.sv */
// 2x2 only; destination comes from the low 4 bits of the first word and holds until tlast
`include "n3xx_macros.svh"

module xbar_stream_switch (
  input  logic                   bus_clk,
  input  logic                   bus_rst,
  input  n3xx_pkg::route_table_t i_route,
  axis_if.sink                   in0,
  axis_if.sink                   in1,
  axis_if.source                 out0,
  axis_if.source                 out1
);

  localparam int NP     = `N3XX_NUM_PORTS;
  localparam int IDX_W  = $clog2(NP);
  localparam int DEST_W = $clog2(`N3XX_ROUTE_ENTRIES);

  n3xx_pkg::stream_data_t in_tdata  [NP];
  n3xx_pkg::stream_data_t out_tdata [NP];
  logic [NP-1:0]          in_tlast;
  logic [NP-1:0]          in_tvalid;
  logic [NP-1:0]          in_tready;
  logic [NP-1:0]          in_busy;    // input owns an output
  logic [NP-1:0]          in_dest;    // output named by the route entry
  logic [NP-1:0]          out_tlast;
  logic [NP-1:0]          out_tvalid;
  logic [NP-1:0]          out_tready;
  logic [NP-1:0]          req [NP];   // req[o][i]
  logic [IDX_W-1:0]       pick [NP];
  n3xx_pkg::out_state_e   state_q [NP];
  logic [IDX_W-1:0]       grant_q [NP];
  logic [IDX_W-1:0]       rr_q [NP];  // preferred input on next contention

  assign {in_tdata[0], in_tlast[0], in_tvalid[0]} = {in0.tdata, in0.tlast, in0.tvalid};
  assign {in_tdata[1], in_tlast[1], in_tvalid[1]} = {in1.tdata, in1.tlast, in1.tvalid};
  assign {in0.tready, in1.tready} = {in_tready[0], in_tready[1]};
  assign {out0.tdata, out0.tlast, out0.tvalid} = {out_tdata[0], out_tlast[0], out_tvalid[0]};
  assign {out1.tdata, out1.tlast, out1.tvalid} = {out_tdata[1], out_tlast[1], out_tvalid[1]};
  assign out_tready = {out1.tready, out0.tready};

  ////////////////////
  // datapath, no register between granted input and output
  always_comb begin
    in_busy   = '0;
    in_tready = '0;
    for (int o = 0; o < NP; o++) begin
      out_tdata[o]  = in_tdata[grant_q[o]];
      out_tlast[o]  = in_tlast[grant_q[o]];
      out_tvalid[o] = (state_q[o] == n3xx_pkg::BUSY) && in_tvalid[grant_q[o]];
      if (state_q[o] == n3xx_pkg::BUSY) begin
        in_busy[grant_q[o]]   = 1'b1;
        in_tready[grant_q[o]] = out_tready[o];
      end
    end
  end

  // an unowned input always presents a first word
  always_comb begin
    for (int i = 0; i < NP; i++) begin
      in_dest[i] = i_route[in_tdata[i][DEST_W-1:0]];
    end
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = in_tvalid[i] && !in_busy[i] && (in_dest[i] == o[0]);
      end
      pick[o] = req[o][rr_q[o]] ? rr_q[o] : ~rr_q[o];
    end
  end

  ////////////////////
  // per-output arbiter FSM
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int o = 0; o < NP; o++) begin
        state_q[o] <= n3xx_pkg::IDLE;
        grant_q[o] <= '0;
        rr_q[o]    <= '0;
      end
    end else begin
      for (int o = 0; o < NP; o++) begin
        case (state_q[o])
          n3xx_pkg::IDLE: if (|req[o]) begin
            state_q[o] <= n3xx_pkg::BUSY;
            grant_q[o] <= pick[o];
          end
          n3xx_pkg::BUSY: if (out_tvalid[o] && out_tready[o] && out_tlast[o]) begin
            state_q[o] <= n3xx_pkg::IDLE;
            rr_q[o]    <= ~grant_q[o];   // other input first next time
          end
          default: state_q[o] <= n3xx_pkg::IDLE;
        endcase
      end
    end
  end

  for (genvar o = 0; o < NP; o++) begin : g_chk
    // holds only if the feeding source keeps its word steady
    a_hold : assert property (@(posedge bus_clk) disable iff (bus_rst)
      out_tvalid[o] && !out_tready[o] |=> out_tvalid[o] && $stable(out_tdata[o]));
  end

  a_excl : assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(state_q[0] == n3xx_pkg::BUSY && state_q[1] == n3xx_pkg::BUSY &&
      grant_q[0] == grant_q[1]));

endmodule

/* source/n3xx_core.sv */
// single bus_clk domain; one register read at a time with 3 or more idle cycles between reads
`include "n3xx_macros.svh"

module n3xx_core (
  input  logic                           bus_clk,
  input  logic                           bus_rst,
  // register port
  input  logic                           i_reg_wr_req,
  input  logic [`N3XX_REG_AWIDTH-1:0]    i_reg_wr_addr,
  input  logic [`N3XX_REG_DWIDTH-1:0]    i_reg_wr_data,
  input  logic                           i_reg_rd_req,
  input  logic [`N3XX_REG_AWIDTH-1:0]    i_reg_rd_addr,
  output logic                           o_reg_rd_resp,
  output logic [`N3XX_REG_DWIDTH-1:0]    o_reg_rd_data,
  // clocking control
  input  logic                           i_ref_clk_locked,
  input  logic                           i_meas_clk_locked,
  output logic [3:0]                     o_pps_select,
  output logic                           o_pps_out_enb,
  output logic                           o_ref_clk_reset,
  output logic                           o_meas_clk_reset,
  // streams
  input  logic [`N3XX_STREAM_WIDTH-1:0]  i_in0_tdata,
  input  logic                           i_in0_tlast,
  input  logic                           i_in0_tvalid,
  output logic                           o_in0_tready,
  input  logic [`N3XX_STREAM_WIDTH-1:0]  i_in1_tdata,
  input  logic                           i_in1_tlast,
  input  logic                           i_in1_tvalid,
  output logic                           o_in1_tready,
  output logic [`N3XX_STREAM_WIDTH-1:0]  o_out0_tdata,
  output logic                           o_out0_tlast,
  output logic                           o_out0_tvalid,
  input  logic                           i_out0_tready,
  output logic [`N3XX_STREAM_WIDTH-1:0]  o_out1_tdata,
  output logic                           o_out1_tlast,
  output logic                           o_out1_tvalid,
  input  logic                           i_out1_tready
);

  regport_if reg_misc ();
  regport_if reg_xbar ();
  axis_if    in0 ();
  axis_if    in1 ();
  axis_if    out0 ();
  axis_if    out1 ();

  n3xx_pkg::route_table_t route;

  ////////////////////
  // both slaves see every request
  assign {reg_misc.wr_req, reg_misc.wr_addr, reg_misc.wr_data} =
    {i_reg_wr_req, i_reg_wr_addr, i_reg_wr_data};
  assign {reg_misc.rd_req, reg_misc.rd_addr} = {i_reg_rd_req, i_reg_rd_addr};
  assign {reg_xbar.wr_req, reg_xbar.wr_addr, reg_xbar.wr_data} =
    {i_reg_wr_req, i_reg_wr_addr, i_reg_wr_data};
  assign {reg_xbar.rd_req, reg_xbar.rd_addr} = {i_reg_rd_req, i_reg_rd_addr};

  assign {in0.tdata, in0.tlast, in0.tvalid} = {i_in0_tdata, i_in0_tlast, i_in0_tvalid};
  assign {in1.tdata, in1.tlast, in1.tvalid} = {i_in1_tdata, i_in1_tlast, i_in1_tvalid};
  assign {o_in0_tready, o_in1_tready} = {in0.tready, in1.tready};
  assign {o_out0_tdata, o_out0_tlast, o_out0_tvalid} = {out0.tdata, out0.tlast, out0.tvalid};
  assign {o_out1_tdata, o_out1_tlast, o_out1_tvalid} = {out1.tdata, out1.tlast, out1.tvalid};
  assign {out0.tready, out1.tready} = {i_out0_tready, i_out1_tready};

  mb_regs mb_regs_i (
    .bus_clk           (bus_clk),
    .bus_rst           (bus_rst),
    .i_ref_clk_locked  (i_ref_clk_locked),
    .i_meas_clk_locked (i_meas_clk_locked),
    .reg_port          (reg_misc),
    .o_pps_select      (o_pps_select),
    .o_pps_out_enb     (o_pps_out_enb),
    .o_ref_clk_reset   (o_ref_clk_reset),
    .o_meas_clk_reset  (o_meas_clk_reset)
  );

  xbar_route_table xbar_route_table_i (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .reg_port (reg_xbar),
    .o_route  (route)
  );

  regport_resp_mux #(
    .NUM_SLAVES (2)
  ) regport_resp_mux_i (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_slave_resp ({reg_xbar.rd_resp, reg_misc.rd_resp}),
    .i_slave_data ({reg_xbar.rd_data, reg_misc.rd_data}),
    .o_rd_resp    (o_reg_rd_resp),
    .o_rd_data    (o_reg_rd_data)
  );

  xbar_stream_switch xbar_stream_switch_i (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_route (route),
    .in0     (in0),
    .in1     (in1),
    .out0    (out0),
    .out1    (out1)
  );

endmodule

/* bench/n3xx_core_tb.sv */
// drives only the top-level pins; register accesses are serial and streams run between them
`include "n3xx_macros.svh"

module n3xx_core_tb;

  localparam int CLK_PERIOD = 40;
  localparam int QTR        = CLK_PERIOD / 4;   // sample point after the falling edge
  localparam int NUM_ACC    = 60;
  localparam int ROUNDS     = 2;
  localparam int NUM_PKTS   = 12;   // per input and round
  localparam int MAX_LEN    = 6;
  localparam int ROUTE_WR   = 8;    // route writes per round
  localparam int ACCESSES   = 40 + 2 * NUM_ACC + 2 * ROUNDS * ROUTE_WR;
  localparam int WATCHDOG_CYCLES = 10 * ACCESSES + 16 * ROUNDS * NUM_PKTS * MAX_LEN + 1000;
  localparam logic [31:0] SEED = 32'h4b45_c2ac;

  // misc register map
  localparam logic [`N3XX_REG_AWIDTH-1:0] A_DESIGN_REV  = 14'h0;
  localparam logic [`N3XX_REG_AWIDTH-1:0] A_BUS_COUNTER = 14'hC;
  localparam logic [`N3XX_REG_AWIDTH-1:0] A_NUM_CE      = 14'h10;
  localparam logic [`N3XX_REG_AWIDTH-1:0] A_SCRATCH     = 14'h14;
  localparam logic [`N3XX_REG_AWIDTH-1:0] A_CLOCK_CTRL  = 14'h18;

  logic                          bus_clk;
  logic                          bus_rst;
  logic                          i_reg_wr_req;
  logic [`N3XX_REG_AWIDTH-1:0]   i_reg_wr_addr;
  logic [`N3XX_REG_DWIDTH-1:0]   i_reg_wr_data;
  logic                          i_reg_rd_req;
  logic [`N3XX_REG_AWIDTH-1:0]   i_reg_rd_addr;
  logic                          o_reg_rd_resp;
  logic [`N3XX_REG_DWIDTH-1:0]   o_reg_rd_data;
  logic                          i_ref_clk_locked;
  logic                          i_meas_clk_locked;
  logic [3:0]                    o_pps_select;
  logic                          o_pps_out_enb;
  logic                          o_ref_clk_reset;
  logic                          o_meas_clk_reset;
  logic [`N3XX_STREAM_WIDTH-1:0] i_in0_tdata;
  logic                          i_in0_tlast;
  logic                          i_in0_tvalid;
  logic                          o_in0_tready;
  logic [`N3XX_STREAM_WIDTH-1:0] i_in1_tdata;
  logic                          i_in1_tlast;
  logic                          i_in1_tvalid;
  logic                          o_in1_tready;
  logic [`N3XX_STREAM_WIDTH-1:0] o_out0_tdata;
  logic                          o_out0_tlast;
  logic                          o_out0_tvalid;
  logic                          i_out0_tready;
  logic [`N3XX_STREAM_WIDTH-1:0] o_out1_tdata;
  logic                          o_out1_tlast;
  logic                          o_out1_tvalid;
  logic                          i_out1_tready;

  ////////////////////
  // reference model
  logic [31:0] exp_scratch;
  logic [3:0]  pps_sel;
  logic        pps_enb;
  logic        ref_rst;
  logic        meas_rst;
  logic        ref_lock;
  logic        meas_lock;
  logic [15:0] route_model;
  logic [64:0] send_q [2][$];   // {tlast, tdata} per input
  logic [64:0] exp_q [4][$];    // index is input * 2 + output
  int unsigned cycle_cnt = 0;
  int unsigned rd_cycle;        // cycle of the last read request

  n3xx_core n3xx_core_i (.*);

  initial bus_clk = 1'b0;
  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  always @(posedge bus_clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before all accesses and packets finished");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      abort_run($sformatf("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                          $time, name, exp, got));
    end
  endtask

  function automatic logic [31:0] expected_clock_ctrl();
    logic [31:0] w;
    w       = '0;
    w[3:0]  = pps_sel;
    w[4]    = pps_enb;
    w[8]    = ref_rst;
    w[9]    = ref_lock;
    w[12]   = meas_rst;
    w[13]   = meas_lock;
    return w;
  endfunction

  function automatic bit is_mapped(input logic [`N3XX_REG_AWIDTH-1:0] a);
    return (a == A_DESIGN_REV) || (a == A_BUS_COUNTER) || (a == A_NUM_CE) ||
           (a == A_SCRATCH) || (a == A_CLOCK_CTRL) ||
           (a >= `N3XX_REG_BASE_XBAR && a <= `N3XX_REG_BASE_XBAR + 14'h3C);
  endfunction

  function automatic logic [`N3XX_REG_AWIDTH-1:0] route_addr(input logic [3:0] entry);
    return `N3XX_REG_BASE_XBAR + {8'b0, entry, 2'b00};
  endfunction

  function automatic int pending_words();
    return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
  endfunction

  ////////////////////
  // register port
  // wr_req stays high until the next step clears it on its falling edge
  task automatic reg_write(input logic [`N3XX_REG_AWIDTH-1:0] addr, input logic [31:0] wdata);
    @(negedge bus_clk);
    i_reg_wr_req  = 1'b1;
    i_reg_wr_addr = addr;
    i_reg_wr_data = wdata;
  endtask

  task automatic reg_read(input logic [`N3XX_REG_AWIDTH-1:0] addr, input bit mapped,
                          output logic [31:0] data);
    @(negedge bus_clk);
    i_reg_wr_req  = 1'b0;
    i_reg_rd_req  = 1'b1;
    i_reg_rd_addr = addr;
    rd_cycle      = cycle_cnt;
    data          = '0;
    for (int c = 1; c <= 4; c++) begin
      @(negedge bus_clk);
      i_reg_rd_req = 1'b0;
      check_value("o_reg_rd_resp", 64'(mapped && c == 2), 64'(o_reg_rd_resp));   // pulse 2 cycles after the request
      if (c == 2) data = o_reg_rd_data;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge bus_clk);
      i_reg_wr_req = 1'b0;
    end
  endtask

  task automatic set_locks(input logic ref_val, input logic meas_val);
    @(negedge bus_clk);
    i_reg_wr_req      = 1'b0;
    i_ref_clk_locked  = ref_val;
    i_meas_clk_locked = meas_val;
    ref_lock          = ref_val;
    meas_lock         = meas_val;
  endtask

  task automatic random_reg_ops();
    logic [31:0] wdata;
    logic [31:0] data;
    logic [`N3XX_REG_AWIDTH-1:0] addr;
    for (int n = 0; n < NUM_ACC; n++) begin
      wdata = $urandom;
      case ($urandom % 5)
        0: begin
          reg_write(A_SCRATCH, wdata);
          exp_scratch = wdata;
          if ($urandom % 2) begin   // read in the cycle after the write
            reg_read(A_SCRATCH, 1'b1, data);
            check_value("SCRATCH", 64'(exp_scratch), 64'(data));
          end
        end
        1: begin
          reg_write(A_CLOCK_CTRL, wdata);
          pps_sel  = wdata[3:0];
          pps_enb  = wdata[4];
          ref_rst  = wdata[8];
          meas_rst = wdata[12];
          reg_read(A_CLOCK_CTRL, 1'b1, data);
          check_value("CLOCK_CTRL", 64'(expected_clock_ctrl()), 64'(data));
          check_value("o_pps_select", 64'(pps_sel), 64'(o_pps_select));
          check_value("o_pps_out_enb", 64'(pps_enb), 64'(o_pps_out_enb));
          check_value("o_ref_clk_reset", 64'(ref_rst), 64'(o_ref_clk_reset));
          check_value("o_meas_clk_reset", 64'(meas_rst), 64'(o_meas_clk_reset));
        end
        2: begin
          reg_read(A_SCRATCH, 1'b1, data);
          check_value("SCRATCH", 64'(exp_scratch), 64'(data));
        end
        3: begin
          reg_read(A_CLOCK_CTRL, 1'b1, data);
          check_value("CLOCK_CTRL", 64'(expected_clock_ctrl()), 64'(data));
        end
        default: begin
          addr = 14'($urandom);
          while (is_mapped(addr)) addr = 14'($urandom);
          reg_read(addr, 1'b0, data);
        end
      endcase
    end
  endtask

  task automatic program_routes();
    logic [3:0]  entry;
    logic [31:0] wdata;
    logic [31:0] data;
    for (int n = 0; n < ROUTE_WR; n++) begin
      entry = 4'($urandom);
      wdata = $urandom;
      reg_write(route_addr(entry), wdata);
      route_model[entry] = wdata[0];   // only bit 0 is kept
      reg_read(route_addr(entry), 1'b1, data);
      check_value($sformatf("route entry %0d", entry), 64'(route_model[entry]), 64'(data));
    end
  endtask

  ////////////////////
  // streams
  // word tag carries input, round, packet and word index up top with dest in word 0's low nibble
  task automatic build_packets(input int round);
    int          len;
    logic [3:0]  dest;
    logic [63:0] data;
    logic [64:0] w;
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < NUM_PKTS; k++) begin
        len  = 1 + ($urandom % MAX_LEN);
        dest = 4'($urandom);
        for (int j = 0; j < len; j++) begin
          data = {8'(p), 8'(round), 8'(k), 8'(j), 32'($urandom)};
          if (j == 0) data[3:0] = dest;
          w = {(j == len - 1), data};
          send_q[p].push_back(w);
          exp_q[p * 2 + int'(route_model[dest])].push_back(w);
        end
      end
    end
  endtask

  task automatic drive_input(input int p, input logic valid, input logic [64:0] w);
    if (p == 0) begin
      i_in0_tvalid = valid;
      i_in0_tlast  = w[64];
      i_in0_tdata  = w[63:0];
    end else begin
      i_in1_tvalid = valid;
      i_in1_tlast  = w[64];
      i_in1_tdata  = w[63:0];
    end
  endtask

  task automatic send_words(input int p);
    logic [64:0] w;
    logic        ready;
    logic        holding;
    holding = 1'b0;
    while (send_q[p].size() > 0) begin
      @(negedge bus_clk);
      w = send_q[p][0];
      if (!holding) holding = ($urandom % 4) != 0;   // gaps only before a new word
      drive_input(p, holding, w);
      #(QTR);
      ready = (p == 0) ? o_in0_tready : o_in1_tready;
      if (holding && ready) begin
        void'(send_q[p].pop_front());
        holding = 1'b0;
      end
    end
    @(negedge bus_clk);
    drive_input(p, 1'b0, '0);
  endtask

  task automatic watch_output(input int o);
    logic        ready;
    logic        valid;
    logic        last;
    logic [63:0] data;
    logic [64:0] exp;
    int          src;
    logic        in_pkt;
    in_pkt = 1'b0;
    src    = 0;
    forever begin
      @(negedge bus_clk);
      ready = ($urandom % 4) != 0;   // random back-pressure
      if (o == 0) i_out0_tready = ready;
      else        i_out1_tready = ready;
      #(QTR);
      valid = (o == 0) ? o_out0_tvalid : o_out1_tvalid;
      last  = (o == 0) ? o_out0_tlast : o_out1_tlast;
      data  = (o == 0) ? o_out0_tdata : o_out1_tdata;
      if (valid && ready) begin
        if (!in_pkt) src = int'(data[63:56]);   // owner stays fixed until tlast
        assert (src < 2 && exp_q[src * 2 + o].size() > 0) else begin
          abort_run($sformatf("unexpected word 0x%0h on output %0d", data, o));
        end
        exp = exp_q[src * 2 + o].pop_front();
        check_value($sformatf("o_out%0d_tdata", o), exp[63:0], data);
        check_value($sformatf("o_out%0d_tlast", o), 64'(exp[64]), 64'(last));
        in_pkt = !last;
      end
    end
  endtask

  ////////////////////
  // main sequence
  initial begin
    logic [31:0] data;
    logic [31:0] c1;
    int unsigned cyc1;
    void'($urandom(SEED));
    bus_rst           = 1'b1;
    i_reg_wr_req      = 1'b0;
    i_reg_wr_addr     = '0;
    i_reg_wr_data     = '0;
    i_reg_rd_req      = 1'b0;
    i_reg_rd_addr     = '0;
    i_ref_clk_locked  = 1'b0;
    i_meas_clk_locked = 1'b0;
    i_out0_tready     = 1'b0;
    i_out1_tready     = 1'b0;
    drive_input(0, 1'b0, '0);
    drive_input(1, 1'b0, '0);
    exp_scratch = '0;
    pps_sel     = 4'h1;
    pps_enb     = 1'b0;
    ref_rst     = 1'b0;
    meas_rst    = 1'b0;
    ref_lock    = 1'b0;
    meas_lock   = 1'b0;
    for (int i = 0; i < 16; i++) route_model[i] = i[0];
    repeat (5) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;
    fork
      watch_output(0);
      watch_output(1);
    join_none

    // reset values
    check_value("o_reg_rd_resp", 64'(0), 64'(o_reg_rd_resp));
    check_value("o_out0_tvalid", 64'(0), 64'(o_out0_tvalid));
    check_value("o_out1_tvalid", 64'(0), 64'(o_out1_tvalid));
    check_value("o_pps_select", 64'(1), 64'(o_pps_select));
    check_value("o_pps_out_enb", 64'(0), 64'(o_pps_out_enb));
    check_value("o_ref_clk_reset", 64'(0), 64'(o_ref_clk_reset));
    check_value("o_meas_clk_reset", 64'(0), 64'(o_meas_clk_reset));
    reg_read(A_CLOCK_CTRL, 1'b1, data);
    check_value("CLOCK_CTRL", 64'(expected_clock_ctrl()), 64'(data));
    reg_read(A_DESIGN_REV, 1'b1, data);
    check_value("DESIGN_REV", 64'(32'h0001_0000), 64'(data));
    reg_read(A_NUM_CE, 1'b1, data);
    check_value("NUM_CE", 64'(2), 64'(data));
    for (int i = 0; i < 16; i++) begin
      reg_read(route_addr(4'(i)), 1'b1, data);
      check_value($sformatf("route entry %0d", i), 64'(route_model[i]), 64'(data));
    end

    // lock bits and bus counter
    for (int n = 1; n <= 4; n++) begin
      set_locks(n[0], n[1]);   // ref and meas step through 10, 01, 11 and back to 00
      idle_cycles(4 + ($urandom % 3));
      reg_read(A_CLOCK_CTRL, 1'b1, data);
      check_value("CLOCK_CTRL", 64'(expected_clock_ctrl()), 64'(data));
    end
    repeat (3) begin
      reg_read(A_BUS_COUNTER, 1'b1, c1);
      cyc1 = rd_cycle;
      idle_cycles($urandom % 12);
      reg_read(A_BUS_COUNTER, 1'b1, data);
      check_value("BUS_COUNTER delta", 64'(rd_cycle - cyc1), 64'(data - c1));
    end

    random_reg_ops();

    // routing under back-pressure
    for (int r = 0; r < ROUNDS; r++) begin
      program_routes();
      build_packets(r);
      fork
        send_words(0);
        send_words(1);
      join
      while (pending_words() != 0) @(negedge bus_clk);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* n3xx_core.f */
+incdir+common
common/n3xx_pkg.sv
common/regport_if.sv
common/axis_if.sv
source/mb_regs.sv
source/regport_resp_mux.sv
xbar/xbar_route_table.sv
xbar/xbar_stream_switch.sv
source/n3xx_core.sv
bench/n3xx_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= n3xx_core_tb
FLIST     ?= n3xx_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) common/n3xx_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
